//--- hdl/rv_pkg.sv
package rv_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [31:0]     addr_t;
    typedef logic [31:0]     instr_t;
    typedef logic [4:0]      reg_idx_t;

    // Supported operations, NOP first so a cleared register is a bubble
    typedef enum logic [3:0] {
        OP_NOP,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_ADDI,
        OP_LW,
        OP_SW,
        OP_BEQ,
        OP_BNE,
        OP_JAL
    } op_e;

    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // funct3 values
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_LW      = 3'b010;
    localparam logic [2:0] F3_SW      = 3'b010;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    // funct7 values
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    // ADDI x0, x0, 0
    localparam instr_t NOP_INSTR = 32'h0000_0013;

endpackage

//--- hdl/id_ex_if.sv
`timescale 1ns/1ps

interface id_ex_if;

    logic             valid;
    rv_pkg::op_e      op;
    rv_pkg::addr_t    pc;
    rv_pkg::reg_idx_t rs1_idx;
    rv_pkg::reg_idx_t rs2_idx;
    rv_pkg::reg_idx_t rd_idx;
    rv_pkg::xlen_t    rs1_val;
    rv_pkg::xlen_t    rs2_val;
    rv_pkg::xlen_t    imm;
    logic             rd_we;

    modport decode_side (
        output valid,
        output op,
        output pc,
        output rs1_idx,
        output rs2_idx,
        output rd_idx,
        output rs1_val,
        output rs2_val,
        output imm,
        output rd_we
    );

    modport execute_side (
        input valid,
        input op,
        input pc,
        input rs1_idx,
        input rs2_idx,
        input rd_idx,
        input rs1_val,
        input rs2_val,
        input imm,
        input rd_we
    );

endinterface

//--- hdl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
    parameter rv_pkg::addr_t RESET_PC = 32'h0000_0000
) (
    input  logic           clk,
    input  logic           rst_n,
    input  rv_pkg::instr_t instr,
    input  logic           load_stall,
    input  logic           redirect,
    input  rv_pkg::addr_t  redirect_pc,
    output rv_pkg::addr_t  pc,
    output rv_pkg::addr_t  if_pc,
    output rv_pkg::instr_t if_instr
);

    // Redirect has priority over the load-use hold
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= RESET_PC;
            if_instr <= rv_pkg::NOP_INSTR;
        end else if (redirect) begin
            pc       <= redirect_pc;
            if_instr <= rv_pkg::NOP_INSTR;
        end else if (!load_stall) begin
            pc       <= pc + 32'd4;
            if_instr <= instr;
        end
    end

    always_ff @(posedge clk) begin
        if (!load_stall) begin
            if_pc <= pc;
        end
    end

endmodule

//--- hdl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic             clk,
    input  logic             rst_n,
    input  rv_pkg::addr_t    if_pc,
    input  rv_pkg::instr_t   if_instr,
    input  logic             redirect,
    input  rv_pkg::xlen_t    rs1_val,
    input  rv_pkg::xlen_t    rs2_val,
    output rv_pkg::reg_idx_t rs1_idx,
    output rv_pkg::reg_idx_t rs2_idx,
    output logic             load_stall,
    id_ex_if.decode_side     id_ex
);

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    rv_pkg::op_e      dec_op;
    rv_pkg::xlen_t    dec_imm;
    logic             dec_rd_we;
    logic             use_rs1;
    logic             use_rs2;
    rv_pkg::xlen_t    imm_i;
    rv_pkg::xlen_t    imm_s;
    rv_pkg::xlen_t    imm_b;
    rv_pkg::xlen_t    imm_j;

    assign opcode = if_instr[6:0];
    assign funct3 = if_instr[14:12];
    assign funct7 = if_instr[31:25];

    assign imm_i = {{20{if_instr[31]}}, if_instr[31:20]};
    assign imm_s = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
    assign imm_b = {{19{if_instr[31]}}, if_instr[31], if_instr[7],
                    if_instr[30:25], if_instr[11:8], 1'b0};
    assign imm_j = {{11{if_instr[31]}}, if_instr[31], if_instr[19:12],
                    if_instr[20], if_instr[30:21], 1'b0};

    always_comb begin
        dec_op    = rv_pkg::OP_NOP;
        dec_imm   = '0;
        dec_rd_we = 1'b0;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        case (opcode)
            rv_pkg::OPC_OP: begin
                if (funct7 == rv_pkg::F7_SUB && funct3 == rv_pkg::F3_ADD_SUB) begin
                    dec_op = rv_pkg::OP_SUB;
                end else if (funct7 == rv_pkg::F7_BASE) begin
                    case (funct3)
                        rv_pkg::F3_ADD_SUB: dec_op = rv_pkg::OP_ADD;
                        rv_pkg::F3_SLT:     dec_op = rv_pkg::OP_SLT;
                        rv_pkg::F3_XOR:     dec_op = rv_pkg::OP_XOR;
                        rv_pkg::F3_OR:      dec_op = rv_pkg::OP_OR;
                        rv_pkg::F3_AND:     dec_op = rv_pkg::OP_AND;
                        default:            dec_op = rv_pkg::OP_NOP;
                    endcase
                end
                dec_rd_we = (dec_op != rv_pkg::OP_NOP);
                use_rs1   = dec_rd_we;
                use_rs2   = dec_rd_we;
            end
            rv_pkg::OPC_OP_IMM: begin
                if (funct3 == rv_pkg::F3_ADD_SUB) begin
                    dec_op    = rv_pkg::OP_ADDI;
                    dec_imm   = imm_i;
                    dec_rd_we = 1'b1;
                    use_rs1   = 1'b1;
                end
            end
            rv_pkg::OPC_LOAD: begin
                if (funct3 == rv_pkg::F3_LW) begin
                    dec_op    = rv_pkg::OP_LW;
                    dec_imm   = imm_i;
                    dec_rd_we = 1'b1;
                    use_rs1   = 1'b1;
                end
            end
            rv_pkg::OPC_STORE: begin
                if (funct3 == rv_pkg::F3_SW) begin
                    dec_op  = rv_pkg::OP_SW;
                    dec_imm = imm_s;
                    use_rs1 = 1'b1;
                    use_rs2 = 1'b1;
                end
            end
            rv_pkg::OPC_BRANCH: begin
                if (funct3 == rv_pkg::F3_BEQ || funct3 == rv_pkg::F3_BNE) begin
                    dec_op  = (funct3 == rv_pkg::F3_BEQ) ? rv_pkg::OP_BEQ : rv_pkg::OP_BNE;
                    dec_imm = imm_b;
                    use_rs1 = 1'b1;
                    use_rs2 = 1'b1;
                end
            end
            rv_pkg::OPC_JAL: begin
                dec_op    = rv_pkg::OP_JAL;
                dec_imm   = imm_j;
                dec_rd_we = 1'b1;
            end
            default: dec_op = rv_pkg::OP_NOP;
        endcase
    end

    // Unused sources read as x0 so they never forward or stall
    assign rs1_idx = use_rs1 ? if_instr[19:15] : '0;
    assign rs2_idx = use_rs2 ? if_instr[24:20] : '0;

    assign load_stall = id_ex.valid && id_ex.op == rv_pkg::OP_LW && id_ex.rd_idx != '0 &&
                        (id_ex.rd_idx == rs1_idx || id_ex.rd_idx == rs2_idx);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex.valid <= 1'b0;
            id_ex.op    <= rv_pkg::OP_NOP;
            id_ex.rd_we <= 1'b0;
        end else if (redirect || load_stall) begin
            id_ex.valid <= 1'b0;
            id_ex.op    <= rv_pkg::OP_NOP;
            id_ex.rd_we <= 1'b0;
        end else begin
            id_ex.valid <= (dec_op != rv_pkg::OP_NOP);
            id_ex.op    <= dec_op;
            id_ex.rd_we <= dec_rd_we;
        end
    end

    always_ff @(posedge clk) begin
        id_ex.pc      <= if_pc;
        id_ex.rs1_idx <= rs1_idx;
        id_ex.rs2_idx <= rs2_idx;
        id_ex.rd_idx  <= if_instr[11:7];
        id_ex.rs1_val <= rs1_val;
        id_ex.rs2_val <= rs2_val;
        id_ex.imm     <= dec_imm;
    end

endmodule

//--- hdl/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic             clk,
    input  logic             rst_n,
    input  rv_pkg::reg_idx_t rs1_idx,
    input  rv_pkg::reg_idx_t rs2_idx,
    input  logic             wb_we,
    input  rv_pkg::reg_idx_t wb_rd,
    input  rv_pkg::xlen_t    wb_value,
    output rv_pkg::xlen_t    rs1_val,
    output rv_pkg::xlen_t    rs2_val
);

    // x0 has no storage
    rv_pkg::xlen_t regs [1:31];

    function automatic rv_pkg::xlen_t read_port(input rv_pkg::reg_idx_t idx);
        rv_pkg::xlen_t val;
        if (idx == '0) begin
            val = '0;
        end else if (wb_we && wb_rd == idx) begin
            val = wb_value;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_comb begin
        rs1_val = read_port(rs1_idx);
        rs2_val = read_port(rs2_idx);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && wb_rd != '0) begin
            regs[wb_rd] <= wb_value;
        end
    end

endmodule

//--- hdl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             wb_we,
    input  rv_pkg::reg_idx_t wb_rd,
    input  rv_pkg::xlen_t    wb_value,
    id_ex_if.execute_side    id_ex,
    output logic             redirect,
    output rv_pkg::addr_t    redirect_pc,
    output logic             mem_valid,
    output rv_pkg::op_e      mem_op,
    output rv_pkg::reg_idx_t mem_rd,
    output logic             mem_rd_we,
    output rv_pkg::xlen_t    mem_result,
    output rv_pkg::xlen_t    mem_store_data
);

    logic          mem_fwd_ok;
    rv_pkg::xlen_t op_a;
    rv_pkg::xlen_t op_b;
    rv_pkg::xlen_t alu_out;
    logic          taken;

    // The decode stall covers loads in EX/MEM
    assign mem_fwd_ok = mem_valid && mem_rd_we && mem_rd != '0 && mem_op != rv_pkg::OP_LW;

    function automatic rv_pkg::xlen_t pick_operand(input rv_pkg::reg_idx_t idx,
                                                   input rv_pkg::xlen_t    dec_val);
        rv_pkg::xlen_t val;
        if (mem_fwd_ok && idx == mem_rd) begin
            val = mem_result;
        end else if (wb_we && idx != '0 && idx == wb_rd) begin
            val = wb_value;
        end else begin
            val = dec_val;
        end
        return val;
    endfunction

    always_comb begin
        op_a = pick_operand(id_ex.rs1_idx, id_ex.rs1_val);
        op_b = pick_operand(id_ex.rs2_idx, id_ex.rs2_val);
    end

    always_comb begin
        case (id_ex.op)
            rv_pkg::OP_ADD:  alu_out = op_a + op_b;
            rv_pkg::OP_SUB:  alu_out = op_a - op_b;
            rv_pkg::OP_AND:  alu_out = op_a & op_b;
            rv_pkg::OP_OR:   alu_out = op_a | op_b;
            rv_pkg::OP_XOR:  alu_out = op_a ^ op_b;
            rv_pkg::OP_SLT:  alu_out = rv_pkg::xlen_t'($signed(op_a) < $signed(op_b));
            rv_pkg::OP_ADDI,
            rv_pkg::OP_LW,
            rv_pkg::OP_SW:   alu_out = op_a + id_ex.imm;
            // Link value
            rv_pkg::OP_JAL:  alu_out = id_ex.pc + 32'd4;
            default:         alu_out = '0;
        endcase
    end

    always_comb begin
        case (id_ex.op)
            rv_pkg::OP_BEQ: taken = (op_a == op_b);
            rv_pkg::OP_BNE: taken = (op_a != op_b);
            rv_pkg::OP_JAL: taken = 1'b1;
            default:        taken = 1'b0;
        endcase
    end

    assign redirect    = id_ex.valid && taken;
    assign redirect_pc = id_ex.pc + id_ex.imm;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_valid <= 1'b0;
            mem_op    <= rv_pkg::OP_NOP;
            mem_rd_we <= 1'b0;
        end else begin
            mem_valid <= id_ex.valid;
            mem_op    <= id_ex.valid ? id_ex.op : rv_pkg::OP_NOP;
            mem_rd_we <= id_ex.valid && id_ex.rd_we;
        end
    end

    always_ff @(posedge clk) begin
        mem_rd         <= id_ex.rd_idx;
        mem_result     <= alu_out;
        mem_store_data <= op_b;
    end

endmodule

//--- hdl/mem_wb_stage.sv
`timescale 1ns/1ps

module mem_wb_stage (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             mem_valid,
    input  rv_pkg::op_e      mem_op,
    input  rv_pkg::reg_idx_t mem_rd,
    input  logic             mem_rd_we,
    input  rv_pkg::xlen_t    mem_result,
    input  rv_pkg::xlen_t    mem_store_data,
    input  rv_pkg::xlen_t    dmem_rd_data,
    output logic             dmem_rd_en,
    output logic             dmem_wr_en,
    output rv_pkg::addr_t    dmem_addr,
    output rv_pkg::xlen_t    dmem_wr_data,
    output logic             wb_we,
    output rv_pkg::reg_idx_t wb_rd,
    output rv_pkg::xlen_t    wb_value
);

    logic          wb_is_load;
    rv_pkg::xlen_t wb_result;
    rv_pkg::xlen_t wb_load_data;

    // One address for both reads and writes
    assign dmem_rd_en   = mem_valid && mem_op == rv_pkg::OP_LW;
    assign dmem_wr_en   = mem_valid && mem_op == rv_pkg::OP_SW;
    assign dmem_addr    = mem_result;
    assign dmem_wr_data = mem_store_data;

    // x0 writes dropped here
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_we      <= 1'b0;
            wb_is_load <= 1'b0;
        end else begin
            wb_we      <= mem_valid && mem_rd_we && mem_rd != '0;
            wb_is_load <= dmem_rd_en;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd        <= mem_rd;
        wb_result    <= mem_result;
        wb_load_data <= dmem_rd_data;
    end

    assign wb_value = wb_is_load ? wb_load_data : wb_result;

endmodule

//--- hdl/riscv_core.sv
`timescale 1ns/1ps

module riscv_core #(
    parameter rv_pkg::addr_t RESET_PC = 32'h0000_0000
) (
    input  logic           clk,
    input  logic           rst_n,
    output rv_pkg::addr_t  pc,
    input  rv_pkg::instr_t instr,
    output logic           dmem_rd_en,
    output logic           dmem_wr_en,
    output rv_pkg::addr_t  dmem_addr,
    output rv_pkg::xlen_t  dmem_wr_data,
    input  rv_pkg::xlen_t  dmem_rd_data
);

    rv_pkg::addr_t    if_pc;
    rv_pkg::instr_t   if_instr;
    logic             load_stall;
    logic             redirect;
    rv_pkg::addr_t    redirect_pc;

    rv_pkg::reg_idx_t rs1_idx;
    rv_pkg::reg_idx_t rs2_idx;
    rv_pkg::xlen_t    rs1_val;
    rv_pkg::xlen_t    rs2_val;

    logic             mem_valid;
    rv_pkg::op_e      mem_op;
    rv_pkg::reg_idx_t mem_rd;
    logic             mem_rd_we;
    rv_pkg::xlen_t    mem_result;
    rv_pkg::xlen_t    mem_store_data;

    logic             wb_we;
    rv_pkg::reg_idx_t wb_rd;
    rv_pkg::xlen_t    wb_value;

    id_ex_if id_ex ();

    fetch_stage #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .load_stall  (load_stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .pc          (pc),
        .if_pc       (if_pc),
        .if_instr    (if_instr)
    );

    decode_stage u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .if_pc      (if_pc),
        .if_instr   (if_instr),
        .redirect   (redirect),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val),
        .rs1_idx    (rs1_idx),
        .rs2_idx    (rs2_idx),
        .load_stall (load_stall),
        .id_ex      (id_ex.decode_side)
    );

    register_file u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .wb_we    (wb_we),
        .wb_rd    (wb_rd),
        .wb_value (wb_value),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val)
    );

    execute_stage u_execute (
        .clk            (clk),
        .rst_n          (rst_n),
        .wb_we          (wb_we),
        .wb_rd          (wb_rd),
        .wb_value       (wb_value),
        .id_ex          (id_ex.execute_side),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc),
        .mem_valid      (mem_valid),
        .mem_op         (mem_op),
        .mem_rd         (mem_rd),
        .mem_rd_we      (mem_rd_we),
        .mem_result     (mem_result),
        .mem_store_data (mem_store_data)
    );

    mem_wb_stage u_mem_wb (
        .clk            (clk),
        .rst_n          (rst_n),
        .mem_valid      (mem_valid),
        .mem_op         (mem_op),
        .mem_rd         (mem_rd),
        .mem_rd_we      (mem_rd_we),
        .mem_result     (mem_result),
        .mem_store_data (mem_store_data),
        .dmem_rd_data   (dmem_rd_data),
        .dmem_rd_en     (dmem_rd_en),
        .dmem_wr_en     (dmem_wr_en),
        .dmem_addr      (dmem_addr),
        .dmem_wr_data   (dmem_wr_data),
        .wb_we          (wb_we),
        .wb_rd          (wb_rd),
        .wb_value       (wb_value)
    );

endmodule

//--- tb/riscv_core_asserts.sv
`timescale 1ns/1ps

module riscv_core_asserts (
    input logic          clk,
    input logic          rst_n,
    input rv_pkg::addr_t pc,
    input logic          dmem_rd_en,
    input logic          dmem_wr_en
);

    // One data address, so never both directions at once
    a_rd_wr_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(dmem_rd_en && dmem_wr_en))
        else $error("dmem_rd_en and dmem_wr_en high together");

    a_pc_aligned: assert property (@(posedge clk) pc[1:0] == 2'b00)
        else $error("pc not word aligned");

    a_idle_in_reset: assert property (@(posedge clk) !rst_n |-> !dmem_rd_en && !dmem_wr_en)
        else $error("data memory enable high during reset");

endmodule

bind riscv_core riscv_core_asserts u_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .pc         (pc),
    .dmem_rd_en (dmem_rd_en),
    .dmem_wr_en (dmem_wr_en)
);

//--- tb/tb_riscv_core.sv
`timescale 1ns/1ps

module tb_riscv_core;

    localparam int            TIMEOUT_CYCLES = 200;
    localparam rv_pkg::addr_t END_ADDR       = 32'h0000_0100;

    logic           clk;
    logic           rst_n;
    rv_pkg::addr_t  pc;
    rv_pkg::instr_t instr;
    logic           dmem_rd_en;
    logic           dmem_wr_en;
    rv_pkg::addr_t  dmem_addr;
    rv_pkg::xlen_t  dmem_wr_data;
    rv_pkg::xlen_t  dmem_rd_data;

    rv_pkg::instr_t imem [0:255];
    rv_pkg::xlen_t  dmem [0:255];

    int prog_len;
    int errors;
    int errors_at_start;
    int tests_run;
    int tests_failed;

    riscv_core #(
        .RESET_PC(32'h0000_0000)
    ) uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .pc           (pc),
        .instr        (instr),
        .dmem_rd_en   (dmem_rd_en),
        .dmem_wr_en   (dmem_wr_en),
        .dmem_addr    (dmem_addr),
        .dmem_wr_data (dmem_wr_data),
        .dmem_rd_data (dmem_rd_data)
    );

    // Both memories answer in the same cycle
    assign instr        = imem[pc[9:2]];
    assign dmem_rd_data = dmem_rd_en ? dmem[dmem_addr[9:2]] : '0;

    always @(posedge clk) begin
        if (dmem_wr_en) begin
            dmem[dmem_addr[9:2]] <= dmem_wr_data;
        end
    end

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic rv_pkg::xlen_t fill_word(input int addr);
        return 32'hdead_0000 ^ addr;
    endfunction

    function automatic rv_pkg::instr_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                             input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], rv_pkg::OPC_OP};
    endfunction

    function automatic rv_pkg::instr_t enc_addi(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], rv_pkg::F3_ADD_SUB, rd[4:0], rv_pkg::OPC_OP_IMM};
    endfunction

    function automatic rv_pkg::instr_t enc_lw(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], rv_pkg::F3_LW, rd[4:0], rv_pkg::OPC_LOAD};
    endfunction

    function automatic rv_pkg::instr_t enc_sw(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], rv_pkg::F3_SW, imm[4:0], rv_pkg::OPC_STORE};
    endfunction

    function automatic rv_pkg::instr_t enc_branch(input logic [2:0] f3, input int rs1,
                                                  input int rs2, input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11],
                rv_pkg::OPC_BRANCH};
    endfunction

    function automatic rv_pkg::instr_t enc_jal(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], rv_pkg::OPC_JAL};
    endfunction

    function automatic rv_pkg::xlen_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    task automatic clear_memories();
        for (int i = 0; i < 256; i++) begin
            imem[i] = rv_pkg::NOP_INSTR;
            dmem[i] = fill_word(i * 4);
        end
        prog_len = 0;
    endtask

    task automatic put(input rv_pkg::instr_t w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    // Reset goes low here and stays low while the program is loaded
    task automatic begin_test();
        @(negedge clk);
        rst_n = 1'b0;
        clear_memories();
        errors_at_start = errors;
    endtask

    task automatic run_program(input string name);
        int  cycles;
        bit  done;
        cycles = 0;
        done   = 1'b0;
        repeat (2) @(negedge clk);
        if (pc !== 32'h0) begin
            $display("error pc: expected %h, got %h", 32'h0, pc);
            errors++;
        end
        rst_n = 1'b1;
        while (!done && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
            if (dmem_wr_en === 1'b1 && dmem_addr === END_ADDR) begin
                done = 1'b1;
            end
        end
        if (done) begin
            // Let the closing store land
            @(negedge clk);
        end else begin
            $display("test %s: timed out after %0d cycles with no store to 0x100",
                     name, TIMEOUT_CYCLES);
            errors++;
        end
    endtask

    task automatic check_word(input rv_pkg::addr_t addr, input rv_pkg::xlen_t exp);
        if (dmem[addr[9:2]] !== exp) begin
            $display("error dmem[%h]: expected %h, got %h", addr, exp, dmem[addr[9:2]]);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errors_at_start);
        end
    endtask

    task automatic test_arith();
        rv_pkg::xlen_t rnd;
        logic [11:0]   imm [0:3];
        rv_pkg::xlen_t a;
        rv_pkg::xlen_t b;
        rv_pkg::xlen_t sum;
        rv_pkg::xlen_t anded;
        rv_pkg::xlen_t ored;
        for (int i = 0; i < 4; i++) begin
            rnd    = $urandom;
            imm[i] = rnd[11:0];
        end
        a     = sext12(imm[0]) + sext12(imm[1]);
        b     = sext12(imm[2]) + sext12(imm[3]);
        sum   = a + b;
        anded = a & b;
        ored  = anded | sum;
        begin_test();
        put(enc_addi(1, 0, imm[0]));
        put(enc_addi(1, 1, imm[1]));
        put(enc_addi(2, 0, imm[2]));
        put(enc_addi(2, 2, imm[3]));
        put(enc_r(rv_pkg::F7_BASE, rv_pkg::F3_ADD_SUB, 3, 1, 2));
        put(enc_r(rv_pkg::F7_SUB, rv_pkg::F3_ADD_SUB, 4, 3, 1));
        put(enc_r(rv_pkg::F7_BASE, rv_pkg::F3_AND, 5, 1, 2));
        put(enc_r(rv_pkg::F7_BASE, rv_pkg::F3_OR, 6, 5, 3));
        put(enc_r(rv_pkg::F7_BASE, rv_pkg::F3_XOR, 7, 6, 2));
        put(enc_r(rv_pkg::F7_BASE, rv_pkg::F3_SLT, 8, 1, 2));
        put(enc_r(rv_pkg::F7_BASE, rv_pkg::F3_SLT, 9, 2, 1));
        for (int r = 3; r <= 9; r++) begin
            put(enc_sw(r, 0, 32'h10 + (r - 3) * 4));
        end
        put(enc_sw(3, 0, END_ADDR));
        run_program("arith");
        check_word(32'h10, sum);
        check_word(32'h14, sum - a);
        check_word(32'h18, anded);
        check_word(32'h1c, ored);
        check_word(32'h20, ored ^ b);
        check_word(32'h24, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        check_word(32'h28, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
        check_word(END_ADDR, sum);
        end_test("arith");
    endtask

    task automatic test_load_use();
        rv_pkg::xlen_t rnd;
        logic [11:0]   imm;
        rnd = $urandom;
        imm = rnd[11:0];
        begin_test();
        put(enc_addi(1, 0, imm));
        put(enc_sw(1, 0, 32'h40));
        put(enc_lw(2, 0, 32'h40));
        put(enc_r(rv_pkg::F7_BASE, rv_pkg::F3_ADD_SUB, 3, 2, 1));
        put(enc_sw(3, 0, 32'h44));
        put(enc_sw(3, 0, END_ADDR));
        run_program("load_use");
        check_word(32'h40, sext12(imm));
        check_word(32'h44, sext12(imm) + sext12(imm));
        check_word(END_ADDR, sext12(imm) + sext12(imm));
        end_test("load_use");
    endtask

    task automatic test_branches();
        begin_test();
        put(enc_addi(1, 0, 5));
        put(enc_addi(2, 0, 5));
        put(enc_addi(3, 0, 32'h0bd));
        put(enc_addi(4, 0, 32'h600));
        // Taken branch that lands on the BNE
        put(enc_branch(rv_pkg::F3_BEQ, 1, 2, 12));
        put(enc_sw(3, 0, 32'h30));
        put(enc_sw(3, 0, 32'h34));
        put(enc_branch(rv_pkg::F3_BNE, 1, 2, 8));
        put(enc_sw(4, 0, 32'h38));
        put(enc_sw(4, 0, END_ADDR));
        run_program("branches");
        check_word(32'h30, fill_word(32'h30));
        check_word(32'h34, fill_word(32'h34));
        check_word(32'h38, 32'h600);
        check_word(END_ADDR, 32'h600);
        end_test("branches");
    endtask

    task automatic test_jal();
        begin_test();
        put(enc_addi(2, 0, 32'h077));
        put(enc_jal(5, 16));
        put(enc_sw(2, 0, 32'h40));
        put(enc_sw(2, 0, 32'h44));
        put(enc_addi(2, 0, 32'h0bd));
        put(enc_sw(5, 0, 32'h48));
        put(enc_sw(2, 0, 32'h4c));
        put(enc_sw(2, 0, END_ADDR));
        run_program("jal");
        check_word(32'h40, fill_word(32'h40));
        check_word(32'h44, fill_word(32'h44));
        check_word(32'h48, 32'h8);
        check_word(32'h4c, 32'h077);
        check_word(END_ADDR, 32'h077);
        end_test("jal");
    endtask

    task automatic test_x0_reset();
        begin_test();
        put(enc_sw(0, 0, 32'h50));
        put(enc_addi(0, 0, 32'h123));
        put(enc_sw(0, 0, 32'h54));
        put(enc_addi(1, 0, 32'h055));
        put(enc_r(rv_pkg::F7_BASE, rv_pkg::F3_ADD_SUB, 0, 1, 1));
        put(enc_sw(0, 0, 32'h58));
        put(enc_sw(1, 0, END_ADDR));
        run_program("x0_reset");
        check_word(32'h50, 32'h0);
        check_word(32'h54, 32'h0);
        check_word(32'h58, 32'h0);
        check_word(END_ADDR, 32'h055);
        end_test("x0_reset");
    endtask

    initial begin
        void'($urandom(68928));
        rst_n           = 1'b0;
        errors          = 0;
        errors_at_start = 0;
        tests_run       = 0;
        tests_failed    = 0;
        clear_memories();
        test_arith();
        test_load_use();
        test_branches();
        test_jal();
        test_x0_reset();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- filelist.f
hdl/rv_pkg.sv
hdl/id_ex_if.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/register_file.sv
hdl/execute_stage.sv
hdl/mem_wb_stage.sv
hdl/riscv_core.sv
tb/riscv_core_asserts.sv
tb/tb_riscv_core.sv
